/* ghostSprite.svh */
// Palette index of every sprite pixel, addressed as GhostPattern[row][col].
// Index 0 inside the sprite shows the background through.
localparam ghostPkg::paletteIdxT GhostPattern [16][16] = '{
	'{3'h0, 3'h0, 3'h0, 3'h0, 3'h0, 3'h0, 3'h1, 3'h0,
	  3'h0, 3'h0, 3'h1, 3'h1, 3'h0, 3'h0, 3'h0, 3'h0}, // Row 0.
	'{3'h0, 3'h0, 3'h0, 3'h0, 3'h1, 3'h1, 3'h0, 3'h1,
	  3'h1, 3'h2, 3'h1, 3'h0, 3'h1, 3'h0, 3'h1, 3'h0},
	'{3'h1, 3'h0, 3'h0, 3'h1, 3'h0, 3'h1, 3'h2, 3'h1,
	  3'h0, 3'h2, 3'h0, 3'h1, 3'h1, 3'h0, 3'h0, 3'h0},
	'{3'h0, 3'h0, 3'h1, 3'h1, 3'h2, 3'h3, 3'h3, 3'h3,
	  3'h3, 3'h2, 3'h2, 3'h1, 3'h2, 3'h1, 3'h0, 3'h1},
	'{3'h0, 3'h1, 3'h2, 3'h3, 3'h3, 3'h3, 3'h3, 3'h4,
	  3'h4, 3'h4, 3'h4, 3'h2, 3'h0, 3'h1, 3'h0, 3'h0}, // Row 4.
	'{3'h0, 3'h1, 3'h5, 3'h3, 3'h4, 3'h4, 3'h4, 3'h4,
	  3'h4, 3'h4, 3'h4, 3'h5, 3'h2, 3'h1, 3'h1, 3'h0},
	'{3'h1, 3'h5, 3'h5, 3'h3, 3'h4, 3'h4, 3'h4, 3'h4,
	  3'h4, 3'h4, 3'h5, 3'h5, 3'h4, 3'h2, 3'h0, 3'h0},
	'{3'h0, 3'h5, 3'h5, 3'h5, 3'h4, 3'h4, 3'h4, 3'h4,
	  3'h5, 3'h5, 3'h5, 3'h5, 3'h4, 3'h2, 3'h1, 3'h0},
	'{3'h0, 3'h5, 3'h6, 3'h5, 3'h5, 3'h4, 3'h4, 3'h5,
	  3'h6, 3'h5, 3'h5, 3'h4, 3'h4, 3'h2, 3'h1, 3'h0}, // Row 8 holds the pupils.
	'{3'h0, 3'h1, 3'h5, 3'h5, 3'h4, 3'h4, 3'h4, 3'h4,
	  3'h5, 3'h5, 3'h4, 3'h4, 3'h4, 3'h2, 3'h1, 3'h0},
	'{3'h1, 3'h1, 3'h4, 3'h4, 3'h4, 3'h4, 3'h4, 3'h4,
	  3'h4, 3'h4, 3'h4, 3'h4, 3'h4, 3'h2, 3'h0, 3'h1},
	'{3'h0, 3'h1, 3'h1, 3'h5, 3'h7, 3'h7, 3'h7, 3'h7,
	  3'h5, 3'h4, 3'h4, 3'h4, 3'h2, 3'h1, 3'h0, 3'h0},
	'{3'h0, 3'h0, 3'h1, 3'h5, 3'h3, 3'h3, 3'h4, 3'h4,
	  3'h5, 3'h4, 3'h4, 3'h2, 3'h1, 3'h0, 3'h0, 3'h0}, // Row 12.
	'{3'h0, 3'h0, 3'h0, 3'h1, 3'h1, 3'h3, 3'h3, 3'h3,
	  3'h4, 3'h2, 3'h1, 3'h0, 3'h0, 3'h1, 3'h1, 3'h0},
	'{3'h0, 3'h0, 3'h1, 3'h0, 3'h0, 3'h1, 3'h1, 3'h2,
	  3'h2, 3'h1, 3'h1, 3'h0, 3'h0, 3'h0, 3'h0, 3'h1},
	'{3'h0, 3'h0, 3'h0, 3'h0, 3'h0, 3'h0, 3'h0, 3'h1,
	  3'h0, 3'h0, 3'h0, 3'h1, 3'h0, 3'h0, 3'h0, 3'h0}
};

/* ghostPkg.sv */
package ghostPkg;

	// ======================================
	// Widths that carry a meaning
	// ======================================
	typedef logic [9:0]  coordT;      // Screen coordinate on either axis.
	typedef logic [11:0] rgb444T;     // Stored colour with 4 bits per channel.
	typedef logic [7:0]  channelT;    // One output colour channel.
	typedef logic [2:0]  paletteIdxT;
	typedef logic [3:0]  offsetT;     // Row or column inside the sprite.

	// A point on the screen. Used for the scan position and the sprite corner.
	typedef struct packed {
		coordT x;
		coordT y;
	} drawPosT;

	typedef struct packed {
		logic   hit;
		offsetT row;
		offsetT col;
	} spriteHitT;

	typedef struct packed {
		channelT red;
		channelT green;
		channelT blue;
	} pixelRgbT;

	// ======================================
	// Screen and sprite geometry
	// ======================================
	localparam int SpriteSize   = 16;
	localparam int ScreenWidth  = 640;
	localparam int ScreenHeight = 480;

	// Largest top-left corner that still keeps the whole sprite on screen.
	localparam coordT MaxX = coordT'(ScreenWidth - SpriteSize);
	localparam coordT MaxY = coordT'(ScreenHeight - SpriteSize);

	// Feedback mask for x^10 + x^7 + 1 with the state shifting right.
	localparam coordT LfsrTaps = 10'h240;

	// ======================================
	// Palette
	// ======================================
	localparam paletteIdxT BackgroundIdx = 3'd0;

	localparam rgb444T GhostPalette [8] = '{
		12'h4ff, // Cyan background.
		12'h73f, // Outline.
		12'h97d,
		12'h335,
		12'h224, // Body.
		12'hfff, // Eye whites.
		12'h000, // Pupils.
		12'hd79  // Mouth.
	};

endpackage

/* ghostPosition.sv */
`timescale 1ns/1ps

module ghostPosition #(
	parameter ghostPkg::coordT InitX = 10'd100,
	parameter ghostPkg::coordT InitY = 10'd200
) (
	input  logic              Clk,
	input  logic              arstN,
	input  logic              Step,  // One-cycle request for a new position.
	output ghostPkg::drawPosT Pos
);
	import ghostPkg::*;

	drawPosT lfsrState; // One LFSR per axis, held as an x and y pair.
	drawPosT lfsrNext;
	logic    acceptX;
	logic    acceptY;

	// One Galois step. The bit shifted out decides whether the taps are applied.
	function automatic coordT galoisStep(input coordT state);
		coordT shifted;
		shifted = state >> 1;
		if (state[0]) begin
			shifted = shifted ^ LfsrTaps;
		end
		return shifted;
	endfunction

	always_comb begin
		lfsrNext.x = galoisStep(lfsrState.x);
		lfsrNext.y = galoisStep(lfsrState.y);

		// A corner past these limits would push part of the sprite off screen.
		acceptX = (lfsrNext.x <= MaxX);
		acceptY = (lfsrNext.y <= MaxY);
	end

	// ======================================
	// LFSR state and accepted position
	// ======================================
	always_ff @(posedge Clk or negedge arstN) begin
		if (!arstN) begin
			lfsrState <= '{x: InitX, y: InitY};
			Pos       <= '{x: InitX, y: InitY};
		end else if (Step) begin
			lfsrState <= lfsrNext; // The sequence moves on even when a value is refused.
			if (acceptX) begin
				Pos.x <= lfsrNext.x;
			end
			if (acceptY) begin
				Pos.y <= lfsrNext.y;
			end
		end
	end

endmodule

/* ghostHitDecode.sv */
`timescale 1ns/1ps

module ghostHitDecode (
	input  logic                Clk,
	input  logic                arstN,
	input  ghostPkg::drawPosT   Draw,  // Coordinate being scanned.
	input  ghostPkg::drawPosT   Pos,   // Top-left corner of the sprite.
	output ghostPkg::spriteHitT Hit
);
	import ghostPkg::*;

	// One bit wider than a coordinate, so a scan point left of or above the
	// sprite sets the top bit instead of wrapping back into range.
	typedef logic [$bits(coordT):0] coordDiffT;

	coordDiffT diffX;
	coordDiffT diffY;
	logic      inX;
	logic      inY;
	spriteHitT hitNext;

	always_comb begin
		diffX = {1'b0, Draw.x} - {1'b0, Pos.x};
		diffY = {1'b0, Draw.y} - {1'b0, Pos.y};

		// Inside the sprite when only the offset bits can be set.
		inX = (diffX[$bits(coordT):$bits(offsetT)] == '0);
		inY = (diffY[$bits(coordT):$bits(offsetT)] == '0);

		hitNext.hit = inX && inY;
		hitNext.row = diffY[$bits(offsetT)-1:0];
		hitNext.col = diffX[$bits(offsetT)-1:0];
	end

	// ======================================
	// Decode register
	// ======================================
	always_ff @(posedge Clk or negedge arstN) begin
		if (!arstN) begin
			Hit <= '0;
		end else begin
			Hit <= hitNext; // Offsets pass through even on a miss.
		end
	end

endmodule

/* ghostPatternLookup.sv */
`timescale 1ns/1ps

module ghostPatternLookup (
	input  logic                 Clk,
	input  logic                 arstN,
	input  ghostPkg::spriteHitT  Hit,
	output ghostPkg::paletteIdxT Idx
);
	import ghostPkg::*;

	`include "ghostSprite.svh"

	paletteIdxT patternIdx;
	paletteIdxT idxNext;

	// Table read for the offset the decode stage produced.
	always_comb begin
		patternIdx = GhostPattern[Hit.row][Hit.col];
	end

	// Points off the sprite fall back to the background entry.
	always_comb begin
		if (Hit.hit) begin
			idxNext = patternIdx;
		end else begin
			idxNext = BackgroundIdx;
		end
	end

	always_ff @(posedge Clk or negedge arstN) begin
		if (!arstN) begin
			Idx <= BackgroundIdx;
		end else begin
			Idx <= idxNext;
		end
	end

endmodule

/* ghostPalette.sv */
`timescale 1ns/1ps

module ghostPalette (
	input  logic                 Clk,
	input  logic                 arstN,
	input  ghostPkg::paletteIdxT Idx,
	output ghostPkg::pixelRgbT   Pixel
);
	import ghostPkg::*;

	rgb444T   colour;
	pixelRgbT pixelNext;

	// Each nibble becomes the upper half of its 8-bit channel.
	function automatic pixelRgbT expandRgb(input rgb444T c);
		pixelRgbT p;
		p.red   = {c[11:8], 4'h0};
		p.green = {c[7:4], 4'h0};
		p.blue  = {c[3:0], 4'h0};
		return p;
	endfunction

	always_comb begin
		colour    = GhostPalette[Idx];
		pixelNext = expandRgb(colour);
	end

	// ======================================
	// Output register
	// ======================================
	always_ff @(posedge Clk or negedge arstN) begin
		if (!arstN) begin
			Pixel <= expandRgb(GhostPalette[BackgroundIdx]);
		end else begin
			Pixel <= pixelNext;
		end
	end

endmodule

/* ghostRenderer.sv */
`timescale 1ns/1ps

module ghostRenderer #(
	parameter ghostPkg::coordT InitX = 10'd100,
	parameter ghostPkg::coordT InitY = 10'd200
) (
	input  logic               Clk,
	input  logic               arstN,
	input  logic               Step,
	input  ghostPkg::drawPosT  Draw,
	output ghostPkg::drawPosT  Pos,
	output ghostPkg::pixelRgbT Pixel
);
	import ghostPkg::*;

	spriteHitT  hit; // Decode to execute.
	paletteIdxT idx; // Execute to result.

	ghostPosition #(
		.InitX(InitX),
		.InitY(InitY)
	) position_i (
		.Clk(Clk),
		.arstN(arstN),
		.Step(Step),
		.Pos(Pos)
	);

	// Three register stages, so Pixel trails Draw by three edges.
	ghostHitDecode decode_i (
		.Clk(Clk),
		.arstN(arstN),
		.Draw(Draw),
		.Pos(Pos),
		.Hit(hit)
	);

	ghostPatternLookup lookup_i (
		.Clk(Clk),
		.arstN(arstN),
		.Hit(hit),
		.Idx(idx)
	);

	ghostPalette palette_i (
		.Clk(Clk),
		.arstN(arstN),
		.Idx(idx),
		.Pixel(Pixel)
	);

endmodule

/* tbGhostRenderer.sv */
`timescale 1ns/1ps

module tbGhostRenderer;
	import ghostPkg::*;

	`include "ghostSprite.svh"

	localparam coordT StartX     = 10'd100;
	localparam coordT StartY     = 10'd200;
	localparam int    PipeDepth  = 3;   // Register stages between Draw and Pixel.
	localparam int    DrainLimit = 10;
	localparam int    StepCount  = 200;
	localparam int    StreamLen  = 600;

	logic     Clk;
	logic     arstN;
	logic     Step;
	drawPosT  Draw;
	drawPosT  Pos;
	pixelRgbT Pixel;

	logic [31:0] randState;
	drawPosT     modelState; // LFSR state per axis, as the DUT keeps it.
	drawPosT     modelPos;
	int          refusedX;
	int          refusedY;
	int unsigned cycleCount = 0;

	// Coordinates in flight, one entry per driven cycle.
	int unsigned cycleQ[$];
	drawPosT     drawQ[$];
	drawPosT     posQ[$];
	string       nameQ[$];

	ghostRenderer #(
		.InitX(StartX),
		.InitY(StartY)
	) dut_i (
		.Clk(Clk),
		.arstN(arstN),
		.Step(Step),
		.Draw(Draw),
		.Pos(Pos),
		.Pixel(Pixel)
	);

	initial begin
		Clk = 1'b0;
		forever #10 Clk = ~Clk;
	end

	always @(posedge Clk) begin
		cycleCount <= cycleCount + 1;
	end

	// ========================================
	// Stimulus source and reference models
	// ========================================
	function automatic logic [31:0] shiftRandom(input logic [31:0] s);
		logic [31:0] r;
		r = s >> 1;
		if (s[0]) begin
			r = r ^ 32'h80200003;
		end
		return r;
	endfunction

	function automatic logic [31:0] randomBits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			randState = shiftRandom(randState);
			r = {r[30:0], randState[0]};
		end
		return r;
	endfunction

	function automatic coordT nextAxisState(input coordT s);
		if (s[0]) begin
			return (s >> 1) ^ LfsrTaps;
		end
		return s >> 1;
	endfunction

	// Every step moves the LFSRs, but a corner that would leave the screen is refused.
	task automatic advancePositionModel();
		drawPosT nextState;
		nextState.x = nextAxisState(modelState.x);
		nextState.y = nextAxisState(modelState.y);
		modelState = nextState;
		if (nextState.x <= MaxX) begin
			modelPos.x = nextState.x;
		end else begin
			refusedX++;
		end
		if (nextState.y <= MaxY) begin
			modelPos.y = nextState.y;
		end else begin
			refusedY++;
		end
	endtask

	function automatic pixelRgbT expectPixel(input drawPosT point, input drawPosT corner);
		int         dx;
		int         dy;
		paletteIdxT idx;
		rgb444T     colour;
		pixelRgbT   p;
		dx = int'(point.x) - int'(corner.x);
		dy = int'(point.y) - int'(corner.y);
		idx = BackgroundIdx;
		if (dx >= 0 && dx < 16 && dy >= 0 && dy < 16) begin
			idx = GhostPattern[offsetT'(dy)][offsetT'(dx)];
		end
		colour = GhostPalette[idx];
		p.red   = {colour[11:8], 4'h0};
		p.green = {colour[7:4], 4'h0};
		p.blue  = {colour[3:0], 4'h0};
		return p;
	endfunction

	// ========================================
	// Checking
	// ========================================
	task automatic stopOnFailure(input string reason);
		$display("RESULT: FAIL");
		$fatal(1, "%s", reason);
	endtask

	task automatic checkPixel(input string name, input pixelRgbT expected,
			input pixelRgbT actual);
		if (actual !== expected) begin
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
			stopOnFailure("Pixel did not match the expected colour.");
		end
	endtask

	task automatic checkPos(input string name, input drawPosT expected,
			input drawPosT actual);
		if (actual !== expected) begin
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
			stopOnFailure("Pos did not match the position model.");
		end
	endtask

	// Pixel is stable half a cycle after the edge that produced it.
	always @(negedge Clk) begin
		if (cycleQ.size() != 0) begin
			if (cycleQ[0] + PipeDepth == cycleCount) begin
				checkPixel(nameQ[0], expectPixel(drawQ[0], posQ[0]), Pixel);
				void'(cycleQ.pop_front());
				void'(drawQ.pop_front());
				void'(posQ.pop_front());
				void'(nameQ.pop_front());
			end else if (cycleQ[0] + PipeDepth < cycleCount) begin
				stopOnFailure("A pixel result passed without being checked.");
			end
		end
	end

	// ========================================
	// Driving
	// ========================================
	task automatic driveCycle(input string name, input drawPosT point, input logic stepNow);
		@(posedge Clk);
		#2;
		checkPos(name, modelPos, Pos); // The last step has landed by now.
		Draw = point;
		Step = stepNow;
		cycleQ.push_back(cycleCount);
		drawQ.push_back(point);
		posQ.push_back(modelPos); // Decode still sees this corner at the next edge.
		nameQ.push_back(name);
		if (stepNow) begin
			advancePositionModel();
		end
	endtask

	function automatic drawPosT randomScreenPoint();
		drawPosT p;
		p.x = coordT'(randomBits(10) % 640);
		p.y = coordT'(randomBits(9) % 480);
		return p;
	endfunction

	task automatic scanSprite();
		drawPosT p;
		for (int row = 0; row < 16; row++) begin
			for (int col = 0; col < 16; col++) begin
				p.x = modelPos.x + coordT'(col);
				p.y = modelPos.y + coordT'(row);
				driveCycle("sprite scan", p, 1'b0);
			end
		end
	endtask

	task automatic probeEdges();
		for (int i = 0; i < 16; i++) begin
			driveCycle("right edge", drawPosT'{x: modelPos.x + 10'd16,
				y: modelPos.y + coordT'(i)}, 1'b0);
			driveCycle("bottom edge", drawPosT'{x: modelPos.x + coordT'(i),
				y: modelPos.y + 10'd16}, 1'b0);
			driveCycle("left edge", drawPosT'{x: modelPos.x - 10'd1,
				y: modelPos.y + coordT'(i)}, 1'b0);
			driveCycle("top edge", drawPosT'{x: modelPos.x + coordT'(i),
				y: modelPos.y - 10'd1}, 1'b0);
		end
	endtask

	task automatic stepPositions();
		int gap;
		for (int n = 0; n < StepCount; n++) begin
			driveCycle("step pulses", randomScreenPoint(), 1'b1);
			gap = int'(randomBits(2));
			for (int g = 0; g < gap; g++) begin
				driveCycle("step pulses", randomScreenPoint(), 1'b0);
			end
		end
		if (refusedX == 0 || refusedY == 0) begin
			stopOnFailure("The step sequence never left an axis unchanged.");
		end
	endtask

	task automatic streamRandom();
		drawPosT p;
		logic    stepNow;
		for (int n = 0; n < StreamLen; n++) begin
			if (randomBits(1) != 0) begin
				// Near the sprite, a few pixels past each side.
				p.x = modelPos.x - 10'd4 + coordT'(randomBits(5));
				p.y = modelPos.y - 10'd4 + coordT'(randomBits(5));
			end else begin
				p = randomScreenPoint();
			end
			stepNow = (randomBits(3) == 0);
			driveCycle("random stream", p, stepNow);
		end
	endtask

	task automatic drainPipeline();
		int waited;
		waited = 0;
		@(posedge Clk);
		#2;
		Step = 1'b0;
		while (cycleQ.size() != 0) begin
			if (waited == DrainLimit) begin
				stopOnFailure("Pixel results were still pending after the pipeline drain.");
			end
			@(posedge Clk);
			waited++;
		end
	endtask

	initial begin
		randState  = 32'h8cc36edf;
		arstN      = 1'b0;
		Step       = 1'b0;
		Draw       = '0;
		modelState = drawPosT'{x: StartX, y: StartY};
		modelPos   = drawPosT'{x: StartX, y: StartY};
		refusedX   = 0;
		refusedY   = 0;

		repeat (5) @(posedge Clk);
		#2;
		arstN = 1'b1;

		checkPos("reset position", drawPosT'{x: StartX, y: StartY}, Pos);
		checkPixel("reset pixel", pixelRgbT'{red: 8'h40, green: 8'hf0, blue: 8'hf0}, Pixel);

		scanSprite();
		probeEdges();
		stepPositions();
		streamRandom();
		drainPipeline();

		$display("RESULT: PASS");
		$finish;
	end

endmodule

/* flist.f */
+incdir+.
ghostPkg.sv
ghostPosition.sv
ghostHitDecode.sv
ghostPatternLookup.sv
ghostPalette.sv
ghostRenderer.sv
tbGhostRenderer.sv

/* run.sh */
#!/bin/sh
# Build and run the ghost renderer testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
	--top-module tbGhostRenderer \
	-f flist.f \
	-o simGhostRenderer

./obj_dir/simGhostRenderer
